/* hw/lane_alu.sv */
`default_nettype none

module lane_alu (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  vfu_op_if.alu                                  vfu,
  // Operand streams
  input  lane_insn_pkg::elem_t                   opnd_a_i,
  input  logic                                   opnd_a_valid_i,
  input  lane_insn_pkg::elem_t                   opnd_b_i,
  input  logic                                   opnd_b_valid_i,
  // Per-queue advance pulse, indexed by opq_e
  output logic [lane_insn_pkg::NrOpQueues-1:0]   consume_o,
  // VRF write port
  output logic                                   alu_we_o,
  output logic [lane_cfg_pkg::VRegW-1:0]         alu_vd_o,
  output logic [lane_cfg_pkg::ElemIdxW-1:0]      alu_elem_o,
  output lane_insn_pkg::elem_t                   alu_data_o
);

  lane_insn_pkg::vfu_operation_t op_q;
  logic                          busy_q;
  lane_insn_pkg::vlen_t          cnt_q;
  lane_insn_pkg::vlen_t          cnt_nxt;
  lane_insn_pkg::vmask_t         done_q;
  lane_insn_pkg::elem_t          opnd_a;
  logic                          need_a;
  logic                          take;

  assign vfu.ready      = ~busy_q;
  assign vfu.vinsn_done = done_q;

  // Scalar replaces operand A
  assign need_a  = ~op_q.use_scalar_op;
  assign opnd_a  = op_q.use_scalar_op ? op_q.scalar_op : opnd_a_i;
  assign cnt_nxt = cnt_q + 1'b1;
  // One element pair once every needed operand is there
  assign take    = busy_q & (cnt_q < op_q.vl) & opnd_b_valid_i & (~need_a | opnd_a_valid_i);

  assign consume_o[lane_insn_pkg::AluA] = take & need_a;
  assign consume_o[lane_insn_pkg::AluB] = take;

  assign alu_we_o   = take;
  assign alu_vd_o   = op_q.vd;
  assign alu_elem_o = cnt_q[lane_cfg_pkg::ElemIdxW-1:0];

  always_comb begin
    case (op_q.op)
      lane_insn_pkg::ADD: alu_data_o = opnd_b_i + opnd_a;
      // RVV order, vs2 minus vs1 or scalar
      lane_insn_pkg::SUB: alu_data_o = opnd_b_i - opnd_a;
      lane_insn_pkg::AND: alu_data_o = opnd_b_i & opnd_a;
      lane_insn_pkg::OR:  alu_data_o = opnd_b_i | opnd_a;
      lane_insn_pkg::XOR: alu_data_o = opnd_b_i ^ opnd_a;
      default:            alu_data_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      done_q <= '0;
    end else begin
      done_q <= '0;
      if (vfu.valid && vfu.ready) begin
        busy_q <= 1'b1;
        cnt_q  <= vfu.op.vstart;
      end else if (busy_q) begin
        if (take) begin
          cnt_q <= cnt_nxt;
          if (cnt_nxt >= op_q.vl) begin
            busy_q           <= 1'b0;
            done_q[op_q.id] <= 1'b1;
          end
        end else if (cnt_q >= op_q.vl) begin
          // Empty share, finish without writing
          busy_q           <= 1'b0;
          done_q[op_q.id] <= 1'b1;
        end
      end
    end
  end

  // Operation payload
  always_ff @(posedge clk_i) begin
    if (vfu.valid && vfu.ready) begin
      op_q <= vfu.op;
    end
  end

endmodule

`default_nettype wire

/* hw/lane_cfg_pkg.sv */
`default_nettype none

package lane_cfg_pkg;

  // Lane count and per-lane register file sizing
  localparam int unsigned NrLanes      = 4;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned ElemsPerLane = 8;
  // Longest vector, spread over all lanes
  localparam int unsigned MaxVl        = NrLanes * ElemsPerLane;
  // Fixed element width
  localparam int unsigned ElemW        = 32;
  // Instruction IDs that can be in flight at once
  localparam int unsigned NrVInsn      = 4;

  // Derived widths
  localparam int unsigned LaneIdW  = $clog2(NrLanes);
  localparam int unsigned VRegW    = $clog2(NrVRegs);
  localparam int unsigned ElemIdxW = $clog2(ElemsPerLane);
  // Lengths must hold MaxVl itself
  localparam int unsigned VlW      = $clog2(MaxVl + 1);
  localparam int unsigned VInsnIdW = $clog2(NrVInsn);

endpackage

`default_nettype wire

/* hw/lane_insn_pkg.sv */
`default_nettype none

package lane_insn_pkg;

  // Operand queues feeding the ALU
  localparam int unsigned NrOpQueues = 2;

  // Field types
  typedef logic [lane_cfg_pkg::VInsnIdW-1:0] vid_t;
  typedef logic [lane_cfg_pkg::VRegW-1:0]    vreg_t;
  typedef logic [lane_cfg_pkg::VlW-1:0]      vlen_t;
  typedef logic [lane_cfg_pkg::ElemW-1:0]    elem_t;
  // One bit per instruction ID
  typedef logic [lane_cfg_pkg::NrVInsn-1:0]  vmask_t;

  // Integer ALU operations
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR
  } alu_op_e;

  // Operand queue index
  typedef enum logic {
    AluA = 1'b0,
    AluB = 1'b1
  } opq_e;

  // Request from the main sequencer, vl and vstart are global
  typedef struct packed {
    vid_t    id;
    alu_op_e op;
    vreg_t   vs1;
    vreg_t   vs2;
    vreg_t   vd;
    logic    use_vs1;
    elem_t   scalar_op;
    logic    use_scalar_op;
    vlen_t   vl;
    vlen_t   vstart;
    vmask_t  hazard_vs1;
    vmask_t  hazard_vs2;
    vmask_t  hazard_vd;
  } pe_req_t;

  // Operand request, vl and vstart are lane-local
  typedef struct packed {
    vid_t   id;
    vreg_t  vs;
    vlen_t  vl;
    vlen_t  vstart;
    vmask_t hazard;
  } operand_cmd_t;

  // Operation handed to the ALU, lane-local lengths
  typedef struct packed {
    vid_t    id;
    alu_op_e op;
    vreg_t   vd;
    vlen_t   vl;
    vlen_t   vstart;
    logic    use_scalar_op;
    elem_t   scalar_op;
  } vfu_operation_t;

endpackage

`default_nettype wire

/* hw/lane_sequencer.sv */
`default_nettype none

module lane_sequencer (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic [lane_cfg_pkg::LaneIdW-1:0]                            lane_id_i,
  // Main sequencer side
  input  lane_insn_pkg::pe_req_t                                      pe_req_i,
  input  logic                                                        pe_req_valid_i,
  output logic                                                        pe_req_ready_o,
  input  lane_insn_pkg::vmask_t                                       vinsn_running_i,
  output lane_insn_pkg::vmask_t                                       vinsn_done_o,
  // Operand request queues
  output lane_insn_pkg::operand_cmd_t [lane_insn_pkg::NrOpQueues-1:0] opcmd_o,
  output logic [lane_insn_pkg::NrOpQueues-1:0]                        opcmd_valid_o,
  input  logic [lane_insn_pkg::NrOpQueues-1:0]                        opcmd_ready_i,
  // ALU operation
  vfu_op_if.seq                                                       vfu
);

  lane_insn_pkg::operand_cmd_t [lane_insn_pkg::NrOpQueues-1:0] opcmd_new;
  lane_insn_pkg::operand_cmd_t [lane_insn_pkg::NrOpQueues-1:0] opcmd_d;
  logic [lane_insn_pkg::NrOpQueues-1:0] opcmd_push;
  logic [lane_insn_pkg::NrOpQueues-1:0] opcmd_valid_d;

  lane_insn_pkg::vfu_operation_t vfu_op_d;
  lane_insn_pkg::vfu_operation_t vfu_op_q;
  logic                          vfu_valid_d;
  logic                          vfu_valid_q;

  lane_insn_pkg::vmask_t running_d;
  lane_insn_pkg::vmask_t running_q;
  lane_insn_pkg::vmask_t done_q;

  // This lane's share of the vector
  lane_insn_pkg::vlen_t vl_lane;
  lane_insn_pkg::vlen_t vstart_lane;

  assign vfu.op       = vfu_op_q;
  assign vfu.valid    = vfu_valid_q;
  assign vinsn_done_o = done_q;

  // Element g sits in lane g mod NrLanes, so low lanes get the remainder
  always_comb begin
    vl_lane = lane_insn_pkg::vlen_t'(pe_req_i.vl / lane_cfg_pkg::NrLanes);
    if (lane_id_i < pe_req_i.vl[lane_cfg_pkg::LaneIdW-1:0]) begin
      vl_lane = vl_lane + 1'b1;
    end
    // Count of elements below vstart that live here
    vstart_lane = lane_insn_pkg::vlen_t'(pe_req_i.vstart / lane_cfg_pkg::NrLanes);
    if (lane_id_i < pe_req_i.vstart[lane_cfg_pkg::LaneIdW-1:0]) begin
      vstart_lane = vstart_lane + 1'b1;
    end
  end

  always_comb begin
    // IDs the main sequencer dropped leave the running set
    running_d      = running_q & vinsn_running_i;
    pe_req_ready_o = 1'b1;
    // Hold the operation until the ALU takes it
    vfu_op_d       = vfu_op_q;
    vfu_valid_d    = vfu_valid_q & ~vfu.ready;
    opcmd_push     = '0;

    // Operand A reads vs1, operand B reads vs2, both wait on vd too
    opcmd_new[lane_insn_pkg::AluA] = '{
      id:     pe_req_i.id,
      vs:     pe_req_i.vs1,
      vl:     vl_lane,
      vstart: vstart_lane,
      hazard: pe_req_i.hazard_vs1 | pe_req_i.hazard_vd
    };
    opcmd_new[lane_insn_pkg::AluB] = '{
      id:     pe_req_i.id,
      vs:     pe_req_i.vs2,
      vl:     vl_lane,
      vstart: vstart_lane,
      hazard: pe_req_i.hazard_vs2 | pe_req_i.hazard_vd
    };

    if (vfu_valid_q && !vfu.ready) begin
      // Previous operation still pending
      pe_req_ready_o = 1'b0;
    end else if (pe_req_valid_i) begin
      if (running_d[pe_req_i.id]) begin
        // ID still in use, refuse
        pe_req_ready_o = 1'b0;
      end else begin
        opcmd_push[lane_insn_pkg::AluA] = pe_req_i.use_vs1 & ~pe_req_i.use_scalar_op;
        opcmd_push[lane_insn_pkg::AluB] = 1'b1;
        if (|(opcmd_push & opcmd_valid_o)) begin
          // A needed queue is occupied, drop the whole request this cycle
          opcmd_push     = '0;
          pe_req_ready_o = 1'b0;
        end else begin
          // Without vs1 the scalar stands in for operand A
          vfu_op_d = '{
            id:            pe_req_i.id,
            op:            pe_req_i.op,
            vd:            pe_req_i.vd,
            vl:            vl_lane,
            vstart:        vstart_lane,
            use_scalar_op: pe_req_i.use_scalar_op | ~pe_req_i.use_vs1,
            scalar_op:     pe_req_i.scalar_op
          };
          vfu_valid_d           = 1'b1;
          running_d[pe_req_i.id] = 1'b1;
        end
      end
    end
  end

  // Operand queues, hazards clear while the command waits
  always_comb begin
    for (int q = 0; q < lane_insn_pkg::NrOpQueues; q++) begin
      opcmd_d[q]       = opcmd_o[q];
      opcmd_valid_d[q] = opcmd_valid_o[q] & ~opcmd_ready_i[q];
      if (opcmd_push[q]) begin
        opcmd_d[q]       = opcmd_new[q];
        opcmd_valid_d[q] = 1'b1;
      end
      opcmd_d[q].hazard = opcmd_d[q].hazard & vinsn_running_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opcmd_o       <= '0;
      opcmd_valid_o <= '0;
      vfu_op_q      <= '0;
      vfu_valid_q   <= 1'b0;
      running_q     <= '0;
      done_q        <= '0;
    end else begin
      opcmd_o       <= opcmd_d;
      opcmd_valid_o <= opcmd_valid_d;
      vfu_op_q      <= vfu_op_d;
      vfu_valid_q   <= vfu_valid_d;
      running_q     <= running_d;
      // Done pulses from the ALU, one cycle later
      done_q        <= vfu.vinsn_done;
    end
  end

endmodule

`default_nettype wire

/* hw/lane_top.sv */
`default_nettype none

module lane_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [lane_cfg_pkg::LaneIdW-1:0]    lane_id_i,
  // Main sequencer
  input  lane_insn_pkg::pe_req_t              pe_req_i,
  input  logic                                pe_req_valid_i,
  output logic                                pe_req_ready_o,
  input  lane_insn_pkg::vmask_t               vinsn_running_i,
  output lane_insn_pkg::vmask_t               vinsn_done_o,
  // Load side write port
  input  logic                                ld_we_i,
  input  logic [lane_cfg_pkg::VRegW-1:0]      ld_vd_i,
  input  logic [lane_cfg_pkg::ElemIdxW-1:0]   ld_elem_i,
  input  lane_insn_pkg::elem_t                ld_data_i,
  // Store side read port
  input  logic [lane_cfg_pkg::VRegW-1:0]      st_vs_i,
  input  logic [lane_cfg_pkg::ElemIdxW-1:0]   st_elem_i,
  output lane_insn_pkg::elem_t                st_data_o
);

  vfu_op_if vfu ();

  lane_insn_pkg::operand_cmd_t [lane_insn_pkg::NrOpQueues-1:0]             opcmd;
  logic [lane_insn_pkg::NrOpQueues-1:0]                                    opcmd_valid;
  logic [lane_insn_pkg::NrOpQueues-1:0]                                    opcmd_ready;
  logic [lane_insn_pkg::NrOpQueues-1:0][lane_cfg_pkg::VRegW-1:0]           rd_vs;
  logic [lane_insn_pkg::NrOpQueues-1:0][lane_cfg_pkg::ElemIdxW-1:0]        rd_elem;
  lane_insn_pkg::elem_t [lane_insn_pkg::NrOpQueues-1:0]                    rd_data;
  lane_insn_pkg::elem_t [lane_insn_pkg::NrOpQueues-1:0]                    opnd;
  logic [lane_insn_pkg::NrOpQueues-1:0]                                    opnd_valid;
  logic [lane_insn_pkg::NrOpQueues-1:0]                                    consume;

  logic                              alu_we;
  logic [lane_cfg_pkg::VRegW-1:0]    alu_vd;
  logic [lane_cfg_pkg::ElemIdxW-1:0] alu_elem;
  lane_insn_pkg::elem_t              alu_data;

  lane_sequencer i_sequencer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lane_id_i       (lane_id_i),
    .pe_req_i        (pe_req_i),
    .pe_req_valid_i  (pe_req_valid_i),
    .pe_req_ready_o  (pe_req_ready_o),
    .vinsn_running_i (vinsn_running_i),
    .vinsn_done_o    (vinsn_done_o),
    .opcmd_o         (opcmd),
    .opcmd_valid_o   (opcmd_valid),
    .opcmd_ready_i   (opcmd_ready),
    .vfu             (vfu)
  );

  // One requester per operand queue, AluA then AluB
  for (genvar q = 0; q < lane_insn_pkg::NrOpQueues; q++) begin : gen_opreq
    operand_requester i_opreq (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .cmd_i           (opcmd[q]),
      .cmd_valid_i     (opcmd_valid[q]),
      .cmd_ready_o     (opcmd_ready[q]),
      .vinsn_running_i (vinsn_running_i),
      .rd_vs_o         (rd_vs[q]),
      .rd_elem_o       (rd_elem[q]),
      .rd_data_i       (rd_data[q]),
      .opnd_o          (opnd[q]),
      .opnd_valid_o    (opnd_valid[q]),
      .consume_i       (consume[q])
    );
  end

  vector_regfile i_vrf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_vs_i    (rd_vs),
    .rd_elem_i  (rd_elem),
    .rd_data_o  (rd_data),
    .st_vs_i    (st_vs_i),
    .st_elem_i  (st_elem_i),
    .st_data_o  (st_data_o),
    .alu_we_i   (alu_we),
    .alu_vd_i   (alu_vd),
    .alu_elem_i (alu_elem),
    .alu_data_i (alu_data),
    .ld_we_i    (ld_we_i),
    .ld_vd_i    (ld_vd_i),
    .ld_elem_i  (ld_elem_i),
    .ld_data_i  (ld_data_i)
  );

  lane_alu i_alu (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .vfu            (vfu),
    .opnd_a_i       (opnd[lane_insn_pkg::AluA]),
    .opnd_a_valid_i (opnd_valid[lane_insn_pkg::AluA]),
    .opnd_b_i       (opnd[lane_insn_pkg::AluB]),
    .opnd_b_valid_i (opnd_valid[lane_insn_pkg::AluB]),
    .consume_o      (consume),
    .alu_we_o       (alu_we),
    .alu_vd_o       (alu_vd),
    .alu_elem_o     (alu_elem),
    .alu_data_o     (alu_data)
  );

endmodule

`default_nettype wire

/* hw/operand_requester.sv */
`default_nettype none

module operand_requester (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Command from the sequencer queue
  input  lane_insn_pkg::operand_cmd_t          cmd_i,
  input  logic                                 cmd_valid_i,
  output logic                                 cmd_ready_o,
  input  lane_insn_pkg::vmask_t                vinsn_running_i,
  // VRF read port
  output logic [lane_cfg_pkg::VRegW-1:0]       rd_vs_o,
  output logic [lane_cfg_pkg::ElemIdxW-1:0]    rd_elem_o,
  input  lane_insn_pkg::elem_t                 rd_data_i,
  // Operand stream to the ALU
  output lane_insn_pkg::elem_t                 opnd_o,
  output logic                                 opnd_valid_o,
  input  logic                                 consume_i
);

  logic                  busy_q;
  lane_insn_pkg::vmask_t hazard_q;
  lane_insn_pkg::vlen_t  cnt_q;
  lane_insn_pkg::vlen_t  cnt_nxt;
  lane_insn_pkg::vreg_t  vs_q;
  lane_insn_pkg::vlen_t  vl_q;
  logic                  hazard_clr;

  // Take a new command only when idle
  assign cmd_ready_o  = cmd_valid_i & ~busy_q;
  assign hazard_clr   = ~|hazard_q;
  assign cnt_nxt      = cnt_q + 1'b1;

  // Read starts the first cycle the hazards are gone
  assign opnd_valid_o = busy_q & hazard_clr & (cnt_q < vl_q);
  assign rd_vs_o      = vs_q;
  assign rd_elem_o    = cnt_q[lane_cfg_pkg::ElemIdxW-1:0];
  // Combinational VRF read, held while the address holds
  assign opnd_o       = rd_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      hazard_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Keep only hazards on IDs that still run
      hazard_q <= hazard_q & vinsn_running_i;
      if (cmd_ready_o) begin
        busy_q   <= 1'b1;
        hazard_q <= cmd_i.hazard & vinsn_running_i;
        cnt_q    <= cmd_i.vstart;
      end else if (busy_q && hazard_clr) begin
        if (opnd_valid_o && consume_i) begin
          cnt_q <= cnt_nxt;
          if (cnt_nxt >= vl_q) begin
            busy_q <= 1'b0;
          end
        end else if (cnt_q >= vl_q) begin
          // Nothing for this lane
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Command payload
  always_ff @(posedge clk_i) begin
    if (cmd_ready_o) begin
      vs_q <= cmd_i.vs;
      vl_q <= cmd_i.vl;
    end
  end

endmodule

`default_nettype wire

/* hw/vector_regfile.sv */
`default_nettype none

module vector_regfile (
  input  logic                                                             clk_i,
  input  logic                                                             rst_ni,
  // Operand requester read ports
  input  logic [lane_insn_pkg::NrOpQueues-1:0][lane_cfg_pkg::VRegW-1:0]    rd_vs_i,
  input  logic [lane_insn_pkg::NrOpQueues-1:0][lane_cfg_pkg::ElemIdxW-1:0] rd_elem_i,
  output lane_insn_pkg::elem_t [lane_insn_pkg::NrOpQueues-1:0]             rd_data_o,
  // Store read port
  input  logic [lane_cfg_pkg::VRegW-1:0]                                   st_vs_i,
  input  logic [lane_cfg_pkg::ElemIdxW-1:0]                                st_elem_i,
  output lane_insn_pkg::elem_t                                             st_data_o,
  // ALU write port
  input  logic                                                             alu_we_i,
  input  logic [lane_cfg_pkg::VRegW-1:0]                                   alu_vd_i,
  input  logic [lane_cfg_pkg::ElemIdxW-1:0]                                alu_elem_i,
  input  lane_insn_pkg::elem_t                                             alu_data_i,
  // Load write port
  input  logic                                                             ld_we_i,
  input  logic [lane_cfg_pkg::VRegW-1:0]                                   ld_vd_i,
  input  logic [lane_cfg_pkg::ElemIdxW-1:0]                                ld_elem_i,
  input  lane_insn_pkg::elem_t                                             ld_data_i
);

  lane_insn_pkg::elem_t mem_q [lane_cfg_pkg::NrVRegs][lane_cfg_pkg::ElemsPerLane];

  // All reads are combinational
  always_comb begin
    for (int q = 0; q < lane_insn_pkg::NrOpQueues; q++) begin
      rd_data_o[q] = mem_q[rd_vs_i[q]][rd_elem_i[q]];
    end
  end

  assign st_data_o = mem_q[st_vs_i][st_elem_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int v = 0; v < lane_cfg_pkg::NrVRegs; v++) begin
        for (int e = 0; e < lane_cfg_pkg::ElemsPerLane; e++) begin
          mem_q[v][e] <= '0;
        end
      end
    end else begin
      if (ld_we_i) begin
        mem_q[ld_vd_i][ld_elem_i] <= ld_data_i;
      end
      // ALU write comes last so it wins on a clash
      if (alu_we_i) begin
        mem_q[alu_vd_i][alu_elem_i] <= alu_data_i;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/vfu_op_if.sv */
`default_nettype none

interface vfu_op_if;

  // Operation and its handshake
  lane_insn_pkg::vfu_operation_t op;
  logic                          valid;
  // High while the ALU is idle
  logic                          ready;
  // One-cycle pulse per finished instruction ID
  lane_insn_pkg::vmask_t         vinsn_done;

  modport seq (output op, output valid, input ready, input vinsn_done);

  modport alu (input op, input valid, output ready, output vinsn_done);

endinterface

`default_nettype wire

/* lane.f */
hw/lane_cfg_pkg.sv
hw/lane_insn_pkg.sv
hw/vfu_op_if.sv
hw/lane_sequencer.sv
hw/operand_requester.sv
hw/vector_regfile.sv
hw/lane_alu.sv
hw/lane_top.sv
verification/tb_lane.sv

/* run_sim.sh */
#!/bin/sh
# Build the lane testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_lane -f lane.f -o sim_lane
./obj_dir/sim_lane | tee sim.log
if grep -qx "test passed" sim.log; then
  echo "Simulation OK"
  exit 0
fi
echo "Simulation reported a failure"
exit 1

/* verification/tb_lane.sv */
`default_nettype none

module tb_lane;
  timeunit 1ns;
  timeprecision 1ps;

  // Run length budget that the timeout doubles
  localparam int unsigned ResetCycles   = 5;
  localparam int unsigned LoadCycles    = lane_cfg_pkg::NrVRegs * lane_cfg_pkg::ElemsPerLane;
  localparam int unsigned NrOps         = 15;
  localparam int unsigned OpCycles      = 6 * lane_cfg_pkg::ElemsPerLane;
  localparam int unsigned HazardCycles  = 12;
  localparam int unsigned RefuseCycles  = 6;
  localparam int unsigned TimeoutCycles =
    2 * (ResetCycles + LoadCycles + NrOps * OpCycles + HazardCycles + RefuseCycles);

  typedef logic [lane_cfg_pkg::ElemIdxW-1:0] eidx_t;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic [lane_cfg_pkg::LaneIdW-1:0]     lane_id_i;
  lane_insn_pkg::pe_req_t               pe_req_i;
  logic                                 pe_req_valid_i;
  logic                                 pe_req_ready_o;
  lane_insn_pkg::vmask_t                vinsn_running_i;
  lane_insn_pkg::vmask_t                vinsn_done_o;
  logic                                 ld_we_i;
  lane_insn_pkg::vreg_t                 ld_vd_i;
  eidx_t                                ld_elem_i;
  lane_insn_pkg::elem_t                 ld_data_i;
  lane_insn_pkg::vreg_t                 st_vs_i;
  eidx_t                                st_elem_i;
  lane_insn_pkg::elem_t                 st_data_o;

  // Lane-local register contents as the testbench expects them
  lane_insn_pkg::elem_t model [lane_cfg_pkg::NrVRegs][lane_cfg_pkg::ElemsPerLane];
  // Done pulses seen per ID, and how many of them were consumed
  int                   done_cnt [lane_cfg_pkg::NrVInsn];
  int                   done_taken [lane_cfg_pkg::NrVInsn];
  int unsigned          cycle_cnt = 0;
  logic                 ready_low_seen;

  lane_top DUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lane_id_i       (lane_id_i),
    .pe_req_i        (pe_req_i),
    .pe_req_valid_i  (pe_req_valid_i),
    .pe_req_ready_o  (pe_req_ready_o),
    .vinsn_running_i (vinsn_running_i),
    .vinsn_done_o    (vinsn_done_o),
    .ld_we_i         (ld_we_i),
    .ld_vd_i         (ld_vd_i),
    .ld_elem_i       (ld_elem_i),
    .ld_data_i       (ld_data_i),
    .st_vs_i         (st_vs_i),
    .st_elem_i       (st_elem_i),
    .st_data_o       (st_data_o)
  );

  always #5 clk_i = ~clk_i;

  // Count done pulses on the falling edge
  always @(negedge clk_i) begin
    for (int i = 0; i < lane_cfg_pkg::NrVInsn; i++) begin
      if (vinsn_done_o[i]) begin
        done_cnt[i] <= done_cnt[i] + 1;
      end
    end
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("test failed");
      $fatal(1, "Simulation timeout");
    end
  end

  function automatic lane_insn_pkg::vmask_t id_mask(input int unsigned id);
    return lane_insn_pkg::vmask_t'(1) << id;
  endfunction

  // Operand b is the vs2 element and a is the vs1 element or the scalar
  function automatic lane_insn_pkg::elem_t compute_op(input lane_insn_pkg::alu_op_e op,
                                                      input lane_insn_pkg::elem_t a,
                                                      input lane_insn_pkg::elem_t b);
    lane_insn_pkg::elem_t res;
    case (op)
      lane_insn_pkg::ADD: res = b + a;
      // vs2 minus vs1 as in vsub
      lane_insn_pkg::SUB: res = b - a;
      lane_insn_pkg::AND: res = b & a;
      lane_insn_pkg::OR:  res = b | a;
      lane_insn_pkg::XOR: res = b ^ a;
      default:            res = '0;
    endcase
    return res;
  endfunction

  // Vector-vector request with no hazards and global vl and vstart
  function automatic lane_insn_pkg::pe_req_t make_req(input int unsigned id,
                                                      input lane_insn_pkg::alu_op_e op,
                                                      input int unsigned vs1,
                                                      input int unsigned vs2,
                                                      input int unsigned vd,
                                                      input int unsigned vl,
                                                      input int unsigned vstart);
    lane_insn_pkg::pe_req_t req;
    req         = '0;
    req.id      = lane_insn_pkg::vid_t'(id);
    req.op      = op;
    req.vs1     = lane_insn_pkg::vreg_t'(vs1);
    req.vs2     = lane_insn_pkg::vreg_t'(vs2);
    req.vd      = lane_insn_pkg::vreg_t'(vd);
    req.use_vs1 = 1'b1;
    req.vl      = lane_insn_pkg::vlen_t'(vl);
    req.vstart  = lane_insn_pkg::vlen_t'(vstart);
    return req;
  endfunction

  task automatic check_equal(input lane_insn_pkg::elem_t got, input lane_insn_pkg::elem_t exp,
                             input string what);
    if (got !== exp) begin
      $display("** Error @ %0d ns: %s: got %08h, expected %08h", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic select_lane(input int unsigned lane);
    @(posedge clk_i);
    lane_id_i <= lane_cfg_pkg::LaneIdW'(lane);
  endtask

  // Random fill of every register through the load port
  task automatic load_regs();
    lane_insn_pkg::elem_t val;
    for (int v = 0; v < lane_cfg_pkg::NrVRegs; v++) begin
      for (int e = 0; e < lane_cfg_pkg::ElemsPerLane; e++) begin
        val = $urandom();
        @(posedge clk_i);
        ld_we_i     <= 1'b1;
        ld_vd_i     <= lane_insn_pkg::vreg_t'(v);
        ld_elem_i   <= eidx_t'(e);
        ld_data_i   <= val;
        model[v][e] = val;
      end
    end
    @(posedge clk_i);
    ld_we_i <= 1'b0;
  endtask

  task automatic read_elem(input int unsigned v, input int unsigned e,
                           output lane_insn_pkg::elem_t data);
    @(posedge clk_i);
    st_vs_i   <= lane_insn_pkg::vreg_t'(v);
    st_elem_i <= eidx_t'(e);
    @(negedge clk_i);
    data = st_data_o;
  endtask

  task automatic verify_vreg(input int unsigned v);
    lane_insn_pkg::elem_t data;
    for (int e = 0; e < lane_cfg_pkg::ElemsPerLane; e++) begin
      read_elem(v, e, data);
      check_equal(data, model[v][e], $sformatf("v%0d element %0d in lane %0d", v, e, lane_id_i));
    end
  endtask

  // Walk the global vector and update the elements owned by this lane
  task automatic apply_model(input lane_insn_pkg::pe_req_t req);
    lane_insn_pkg::elem_t opnd_a;
    int unsigned          lane;
    int unsigned          vl;
    int unsigned          vstart;
    int unsigned          idx;
    lane   = lane_id_i;
    vl     = req.vl;
    vstart = req.vstart;
    for (int unsigned g = 0; g < lane_cfg_pkg::MaxVl; g++) begin
      idx = g / lane_cfg_pkg::NrLanes;
      if ((g % lane_cfg_pkg::NrLanes) == lane && g >= vstart && g < vl) begin
        opnd_a = req.use_scalar_op ? req.scalar_op : model[req.vs1][idx];
        model[req.vd][idx] = compute_op(req.op, opnd_a, model[req.vs2][idx]);
      end
    end
  endtask

  // Hold valid until ready, then mark the ID running like the main sequencer
  task automatic wait_accept(input int unsigned id);
    @(negedge clk_i);
    while (!pe_req_ready_o) begin
      ready_low_seen = 1'b1;
      @(negedge clk_i);
    end
    // Transfer happens on this edge
    @(posedge clk_i);
    pe_req_valid_i  <= 1'b0;
    vinsn_running_i <= vinsn_running_i | id_mask(id);
  endtask

  task automatic send_req(input lane_insn_pkg::pe_req_t req);
    @(posedge clk_i);
    pe_req_i       <= req;
    pe_req_valid_i <= 1'b1;
    wait_accept(req.id);
  endtask

  task automatic wait_done(input int unsigned id, input bit release_id);
    while (done_cnt[id] == done_taken[id]) begin
      @(negedge clk_i);
    end
    done_taken[id]++;
    if (release_id) begin
      @(posedge clk_i);
      vinsn_running_i <= vinsn_running_i & ~id_mask(id);
    end
  endtask

  task automatic run_op(input lane_insn_pkg::pe_req_t req);
    send_req(req);
    wait_done(req.id, 1'b1);
    apply_model(req);
    verify_vreg(req.vd);
  endtask

  task automatic vv_add_full();
    select_lane(1);
    run_op(make_req(0, lane_insn_pkg::ADD, 1, 2, 3, lane_cfg_pkg::MaxVl, 0));
  endtask

  // Uneven vl over several lanes
  task automatic partial_lanes_ops();
    select_lane(0);
    run_op(make_req(1, lane_insn_pkg::SUB, 4, 5, 6, 7, 0));
    select_lane(1);
    run_op(make_req(2, lane_insn_pkg::AND, 2, 6, 7, 13, 0));
    select_lane(2);
    run_op(make_req(3, lane_insn_pkg::OR, 1, 4, 0, 30, 0));
    select_lane(3);
    run_op(make_req(0, lane_insn_pkg::XOR, 3, 5, 2, 21, 0));
    // Lane 3 owns nothing of a two-element vector
    run_op(make_req(1, lane_insn_pkg::OR, 4, 5, 1, 2, 0));
  endtask

  task automatic vstart_skip();
    select_lane(2);
    run_op(make_req(2, lane_insn_pkg::ADD, 5, 6, 4, lane_cfg_pkg::MaxVl, 6));
    select_lane(1);
    run_op(make_req(3, lane_insn_pkg::SUB, 7, 0, 5, 27, 9));
  endtask

  task automatic scalar_ops();
    lane_insn_pkg::pe_req_t req;
    select_lane(3);
    req               = make_req(0, lane_insn_pkg::ADD, 0, 6, 7, lane_cfg_pkg::MaxVl, 0);
    req.use_vs1       = 1'b0;
    req.use_scalar_op = 1'b1;
    req.scalar_op     = $urandom();
    run_op(req);
    req               = make_req(1, lane_insn_pkg::SUB, 0, 3, 1, lane_cfg_pkg::MaxVl, 0);
    req.use_vs1       = 1'b0;
    req.use_scalar_op = 1'b1;
    req.scalar_op     = $urandom();
    run_op(req);
  endtask

  task automatic hazard_hold();
    lane_insn_pkg::pe_req_t req;
    select_lane(0);
    // ID 2 stands for an older instruction still producing v3
    @(posedge clk_i);
    vinsn_running_i <= vinsn_running_i | id_mask(2);
    req            = make_req(1, lane_insn_pkg::ADD, 3, 4, 6, lane_cfg_pkg::MaxVl, 0);
    req.hazard_vs1 = id_mask(2);
    send_req(req);
    repeat (HazardCycles) @(posedge clk_i);
    check_equal(done_cnt[1], done_taken[1], "done count of ID 1 while hazard held");
    // Model not yet updated, so vd must still hold old data
    verify_vreg(6);
    @(posedge clk_i);
    vinsn_running_i <= vinsn_running_i & ~id_mask(2);
    wait_done(1, 1'b1);
    apply_model(req);
    verify_vreg(6);
  endtask

  task automatic back_to_back();
    lane_insn_pkg::pe_req_t req_a;
    lane_insn_pkg::pe_req_t req_b;
    lane_insn_pkg::pe_req_t req_c;
    lane_insn_pkg::pe_req_t req_d;
    select_lane(1);
    // Destinations are disjoint so no ordering is needed
    req_a = make_req(0, lane_insn_pkg::ADD, 1, 2, 5, lane_cfg_pkg::MaxVl, 0);
    req_b = make_req(1, lane_insn_pkg::XOR, 3, 4, 6, lane_cfg_pkg::MaxVl, 0);
    req_c = make_req(2, lane_insn_pkg::OR, 0, 1, 7, lane_cfg_pkg::MaxVl, 0);
    ready_low_seen = 1'b0;
    send_req(req_a);
    send_req(req_b);
    send_req(req_c);
    check_equal(ready_low_seen, 1'b1, "pe_req_ready_o low while ALU busy");
    wait_done(0, 1'b1);
    wait_done(1, 1'b1);
    // ID 2 stays running on the main sequencer side
    wait_done(2, 1'b0);
    apply_model(req_a);
    apply_model(req_b);
    apply_model(req_c);
    verify_vreg(5);
    verify_vreg(6);
    verify_vreg(7);
    req_d = make_req(2, lane_insn_pkg::SUB, 5, 6, 0, lane_cfg_pkg::MaxVl, 0);
    @(posedge clk_i);
    pe_req_i       <= req_d;
    pe_req_valid_i <= 1'b1;
    repeat (RefuseCycles) begin
      @(negedge clk_i);
      check_equal(pe_req_ready_o, 1'b0, "pe_req_ready_o for an ID still running");
    end
    @(posedge clk_i);
    vinsn_running_i <= vinsn_running_i & ~id_mask(2);
    wait_accept(2);
    wait_done(2, 1'b1);
    apply_model(req_d);
    verify_vreg(0);
  endtask

  initial begin
    void'($urandom(32'h07c1_f85a));
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    lane_id_i       = '0;
    pe_req_i        = '0;
    pe_req_valid_i  = 1'b0;
    vinsn_running_i = '0;
    ld_we_i         = 1'b0;
    ld_vd_i         = '0;
    ld_elem_i       = '0;
    ld_data_i       = '0;
    st_vs_i         = '0;
    st_elem_i       = '0;
    ready_low_seen  = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    load_regs();
    vv_add_full();
    partial_lanes_ops();
    vstart_skip();
    scalar_ops();
    hazard_hold();
    back_to_back();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
